// ==== rtl/id_pkg.sv ====
// word and register address types, opcode, function, alu operation and result class enums
package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // primary opcodes, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_addi    = 6'b001000,
        op_addiu   = 6'b001001,
        op_slti    = 6'b001010,
        op_sltiu   = 6'b001011,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_xori    = 6'b001110,
        op_lui     = 6'b001111,
        op_pref    = 6'b110011
    } op_e;

    // SPECIAL function field, inst[5:0]
    typedef enum logic [5:0] {
        func_sll  = 6'b000000,
        func_srl  = 6'b000010,
        func_sra  = 6'b000011,
        func_sllv = 6'b000100,
        func_srlv = 6'b000110,
        func_srav = 6'b000111,
        func_movz = 6'b001010,
        func_movn = 6'b001011,
        func_sync = 6'b001111,
        func_add  = 6'b100000,
        func_addu = 6'b100001,
        func_sub  = 6'b100010,
        func_subu = 6'b100011,
        func_and  = 6'b100100,
        func_or   = 6'b100101,
        func_xor  = 6'b100110,
        func_nor  = 6'b100111,
        func_slt  = 6'b101010,
        func_sltu = 6'b101011
    } func_e;

    // operation handed to the execute stage
    typedef enum logic [7:0] {
        alu_nop   = 8'b00000000,
        alu_srl   = 8'b00000010,
        alu_sra   = 8'b00000011,
        alu_movz  = 8'b00001010,
        alu_movn  = 8'b00001011,
        alu_add   = 8'b00100000,
        alu_addu  = 8'b00100001,
        alu_sub   = 8'b00100010,
        alu_subu  = 8'b00100011,
        alu_and   = 8'b00100100,
        alu_or    = 8'b00100101,
        alu_xor   = 8'b00100110,
        alu_nor   = 8'b00100111,
        alu_slt   = 8'b00101010,
        alu_sltu  = 8'b00101011,
        alu_addi  = 8'b01010101,
        alu_addiu = 8'b01010110,
        alu_sll   = 8'b01111100
    } alu_op_e;

    // result class, picks the execute-stage result mux leg
    typedef enum logic [2:0] {
        sel_nop   = 3'b000,
        sel_logic = 3'b001,
        sel_shift = 3'b010,
        sel_move  = 3'b011,
        sel_arith = 3'b100
    } alu_sel_e;

endpackage

// ==== rtl/inst_decoder.sv ====
// instruction decoder: operation, result class, read ports, immediate, destination, validity
`timescale 1ns/1ps

module inst_decoder import id_pkg::*; (
    input  word_t     inst_i,
    input  word_t     src2_i,   // selected rt operand, for movz/movn
    output alu_op_e   aluop_o,
    output alu_sel_e  alusel_o,
    output logic      read1_o,
    output logic      read2_o,
    output reg_addr_t addr1_o,
    output reg_addr_t addr2_o,
    output word_t     imm_o,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output logic      invalid_o
);

    op_e       op;
    func_e     func;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t sa;
    logic [15:0] imm16;

    logic rr_form;   // reads rs and rt, writes rd
    logic ri_form;   // reads rs, writes rt
    logic sh_form;   // reads rt only, shift amount as immediate
    logic mov_z;
    logic mov_n;
    logic wreg_d;

    assign op    = op_e'(inst_i[31:26]);
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign sa    = inst_i[10:6];
    assign func  = func_e'(inst_i[5:0]);
    assign imm16 = inst_i[15:0];

    always_comb begin
        aluop_o   = alu_nop;
        alusel_o  = sel_nop;
        read1_o   = 1'b0;
        read2_o   = 1'b0;
        addr1_o   = '0;
        addr2_o   = '0;
        imm_o     = '0;
        wd_o      = '0;
        wreg_d    = 1'b0;
        invalid_o = 1'b0;
        rr_form   = 1'b0;
        ri_form   = 1'b0;
        sh_form   = 1'b0;
        mov_z     = 1'b0;
        mov_n     = 1'b0;

        // first pass picks the operation and the operand form
        case (op)
            op_special: begin
                case (func)
                    func_and:  {aluop_o, alusel_o, rr_form} = {alu_and, sel_logic, 1'b1};
                    func_or:   {aluop_o, alusel_o, rr_form} = {alu_or, sel_logic, 1'b1};
                    func_xor:  {aluop_o, alusel_o, rr_form} = {alu_xor, sel_logic, 1'b1};
                    func_nor:  {aluop_o, alusel_o, rr_form} = {alu_nor, sel_logic, 1'b1};
                    func_sll:  {aluop_o, alusel_o, sh_form} = {alu_sll, sel_shift, 1'b1};
                    func_srl:  {aluop_o, alusel_o, sh_form} = {alu_srl, sel_shift, 1'b1};
                    func_sra:  {aluop_o, alusel_o, sh_form} = {alu_sra, sel_shift, 1'b1};
                    func_sllv: {aluop_o, alusel_o, rr_form} = {alu_sll, sel_shift, 1'b1};
                    func_srlv: {aluop_o, alusel_o, rr_form} = {alu_srl, sel_shift, 1'b1};
                    func_srav: {aluop_o, alusel_o, rr_form} = {alu_sra, sel_shift, 1'b1};
                    func_movz: {aluop_o, alusel_o, rr_form, mov_z} = {alu_movz, sel_move, 2'b11};
                    func_movn: {aluop_o, alusel_o, rr_form, mov_n} = {alu_movn, sel_move, 2'b11};
                    func_add:  {aluop_o, alusel_o, rr_form} = {alu_add, sel_arith, 1'b1};
                    func_addu: {aluop_o, alusel_o, rr_form} = {alu_addu, sel_arith, 1'b1};
                    func_sub:  {aluop_o, alusel_o, rr_form} = {alu_sub, sel_arith, 1'b1};
                    func_subu: {aluop_o, alusel_o, rr_form} = {alu_subu, sel_arith, 1'b1};
                    func_slt:  {aluop_o, alusel_o, rr_form} = {alu_slt, sel_arith, 1'b1};
                    func_sltu: {aluop_o, alusel_o, rr_form} = {alu_sltu, sel_arith, 1'b1};
                    func_sync: aluop_o = alu_nop;   // ordering barrier, nothing in this core
                    default:   invalid_o = 1'b1;
                endcase
            end
            // immediates: logic ops zero-extend, arithmetic ops sign-extend
            op_andi: begin
                {aluop_o, alusel_o, ri_form} = {alu_and, sel_logic, 1'b1};
                imm_o = {16'b0, imm16};
            end
            op_ori: begin
                {aluop_o, alusel_o, ri_form} = {alu_or, sel_logic, 1'b1};
                imm_o = {16'b0, imm16};
            end
            op_xori: begin
                {aluop_o, alusel_o, ri_form} = {alu_xor, sel_logic, 1'b1};
                imm_o = {16'b0, imm16};
            end
            op_lui: begin
                {aluop_o, alusel_o, ri_form} = {alu_or, sel_logic, 1'b1};
                imm_o = {imm16, 16'b0};   // or'ed with rs in ex
            end
            op_addi: begin
                {aluop_o, alusel_o, ri_form} = {alu_addi, sel_arith, 1'b1};
                imm_o = {{16{imm16[15]}}, imm16};
            end
            op_addiu: begin
                {aluop_o, alusel_o, ri_form} = {alu_addiu, sel_arith, 1'b1};
                imm_o = {{16{imm16[15]}}, imm16};
            end
            op_slti: begin
                {aluop_o, alusel_o, ri_form} = {alu_slt, sel_arith, 1'b1};
                imm_o = {{16{imm16[15]}}, imm16};
            end
            op_sltiu: begin
                {aluop_o, alusel_o, ri_form} = {alu_sltu, sel_arith, 1'b1};
                imm_o = {{16{imm16[15]}}, imm16};
            end
            op_pref: aluop_o = alu_nop;   // prefetch hint, ignored
            default: invalid_o = 1'b1;
        endcase

        // second pass maps the form onto ports and destination
        if (rr_form) begin
            read1_o = 1'b1;
            addr1_o = rs;
            read2_o = 1'b1;
            addr2_o = rt;
            wd_o    = rd;
            wreg_d  = !(mov_z || mov_n);   // moves decide below
        end
        if (ri_form) begin
            read1_o = 1'b1;
            addr1_o = rs;
            wd_o    = rt;
            wreg_d  = 1'b1;
        end
        if (sh_form) begin
            read2_o = 1'b1;
            addr2_o = rt;
            imm_o   = {27'b0, sa};
            wd_o    = rd;
            wreg_d  = 1'b1;
        end
    end

    // conditional moves look at the forwarded rt value
    assign wreg_o = wreg_d
                  | (mov_z && (src2_i == '0))
                  | (mov_n && (src2_i != '0));

endmodule

// ==== rtl/operand_select.sv ====
// operand source select: ex forward, mem forward, register file, immediate
`timescale 1ns/1ps

module operand_select import id_pkg::*; (
    input  logic      read_i,
    input  reg_addr_t addr_i,
    input  word_t     imm_i,
    input  word_t     reg_data_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    output word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 not excluded, a write to r0 still forwards
    assign ex_hit  = ex_wreg_i && (addr_i == ex_wd_i);
    assign mem_hit = mem_wreg_i && (addr_i == mem_wd_i);

    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_wdata_i;   // youngest result wins
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = reg_data_i;
        end
    end

endmodule

// ==== rtl/id_ex_reg.sv ====
// id/ex pipeline register
`timescale 1ns/1ps

module id_ex_reg import id_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  alu_op_e   aluop_i,
    input  alu_sel_e  alusel_i,
    input  word_t     reg1_i,
    input  word_t     reg2_i,
    input  reg_addr_t wd_i,
    input  logic      wreg_i,
    input  logic      invalid_i,
    output alu_op_e   aluop_o,
    output alu_sel_e  alusel_o,
    output word_t     reg1_o,
    output word_t     reg2_o,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output logic      invalid_o
);

    // reset loads a bubble so ex sees a nop
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            aluop_o   <= alu_nop;
            alusel_o  <= sel_nop;
            reg1_o    <= '0;
            reg2_o    <= '0;
            wd_o      <= '0;
            wreg_o    <= 1'b0;
            invalid_o <= 1'b0;
        end else begin
            aluop_o   <= aluop_i;
            alusel_o  <= alusel_i;
            reg1_o    <= reg1_i;
            reg2_o    <= reg2_i;
            wd_o      <= wd_i;
            wreg_o    <= wreg_i;
            invalid_o <= invalid_i;
        end
    end

endmodule

// ==== rtl/id_stage.sv ====
// instruction decode stage: decoder, two operand selectors, id/ex register
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  word_t     inst_i,
    input  word_t     reg1_data_i,
    input  word_t     reg2_data_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    output logic      reg1_read_o,
    output logic      reg2_read_o,
    output reg_addr_t reg1_addr_o,
    output reg_addr_t reg2_addr_o,
    output alu_op_e   aluop_o,
    output alu_sel_e  alusel_o,
    output word_t     reg1_o,
    output word_t     reg2_o,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output logic      inst_invalid_o
);

    alu_op_e   dec_aluop;
    alu_sel_e  dec_alusel;
    word_t     dec_imm;
    reg_addr_t dec_wd;
    logic      dec_wreg;
    logic      dec_invalid;
    word_t     src1;
    word_t     src2;

    inst_decoder u_dec (
        .inst_i    (inst_i),
        .src2_i    (src2),
        .aluop_o   (dec_aluop),
        .alusel_o  (dec_alusel),
        .read1_o   (reg1_read_o),
        .read2_o   (reg2_read_o),
        .addr1_o   (reg1_addr_o),
        .addr2_o   (reg2_addr_o),
        .imm_o     (dec_imm),
        .wd_o      (dec_wd),
        .wreg_o    (dec_wreg),
        .invalid_o (dec_invalid)
    );

    operand_select u_src1 (
        .read_i      (reg1_read_o),
        .addr_i      (reg1_addr_o),
        .imm_i       (dec_imm),
        .reg_data_i  (reg1_data_i),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (src1)
    );

    operand_select u_src2 (
        .read_i      (reg2_read_o),
        .addr_i      (reg2_addr_o),
        .imm_i       (dec_imm),
        .reg_data_i  (reg2_data_i),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (src2)
    );

    id_ex_reg u_idex (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .aluop_i   (dec_aluop),
        .alusel_i  (dec_alusel),
        .reg1_i    (src1),
        .reg2_i    (src2),
        .wd_i      (dec_wd),
        .wreg_i    (dec_wreg),
        .invalid_i (dec_invalid),
        .aluop_o   (aluop_o),
        .alusel_o  (alusel_o),
        .reg1_o    (reg1_o),
        .reg2_o    (reg2_o),
        .wd_o      (wd_o),
        .wreg_o    (wreg_o),
        .invalid_o (inst_invalid_o)
    );

endmodule

// ==== verif/id_stage_tb.sv ====
// directed testbench for id_stage: register file model, LFSR data, compare tasks, watchdog
`timescale 1ns/1ps

module id_stage_tb import id_pkg::*; ();

    localparam int RESET_CYCLES    = 5;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 40;
    localparam int TIMEOUT_NS      = (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * 20 + 2000;

    logic      clk;
    logic      arst_n_i;
    word_t     inst_i;
    word_t     reg1_data_i;
    word_t     reg2_data_i;
    logic      ex_wreg_i;
    reg_addr_t ex_wd_i;
    word_t     ex_wdata_i;
    logic      mem_wreg_i;
    reg_addr_t mem_wd_i;
    word_t     mem_wdata_i;
    logic      reg1_read_o;
    logic      reg2_read_o;
    reg_addr_t reg1_addr_o;
    reg_addr_t reg2_addr_o;
    alu_op_e   aluop_o;
    alu_sel_e  alusel_o;
    word_t     reg1_o;
    word_t     reg2_o;
    reg_addr_t wd_o;
    logic      wreg_o;
    logic      inst_invalid_o;

    word_t     rf [32];   // register file model
    word_t     lfsr_state;
    int        errors;
    int        checks;
    int        tests;

    // forwarding values applied with the next instruction
    logic      fwd_ex_we;
    reg_addr_t fwd_ex_wd;
    word_t     fwd_ex_data;
    logic      fwd_mem_we;
    reg_addr_t fwd_mem_wd;
    word_t     fwd_mem_data;

    id_stage dut_i (.*);

    always #10 clk = ~clk;

    assign reg1_data_i = rf[reg1_addr_o];   // same-cycle read
    assign reg2_data_i = rf[reg2_addr_o];

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic word_t enc_r(input logic [5:0] f, input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, input logic [4:0] sa);
        return {6'b000000, rs, rt, rd, sa, f};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // source priority: ex forward, mem forward, register file, immediate
    function automatic word_t exp_operand(input logic rd, input reg_addr_t a, input word_t imm);
        if (!rd) return imm;
        if (fwd_ex_we && a == fwd_ex_wd) return fwd_ex_data;
        if (fwd_mem_we && a == fwd_mem_wd) return fwd_mem_data;
        return rf[a];
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %0d ns %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %0d ns %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %0d ns %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_aluop(input string name, input alu_op_e exp, input alu_op_e act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %0d ns %s expected %s got %s", $time, name, exp.name(), act.name());
        end
    endtask

    task automatic check_alusel(input string name, input alu_sel_e exp, input alu_sel_e act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %0d ns %s expected %s got %s", $time, name, exp.name(), act.name());
        end
    endtask

    // present one instruction, check read ports now and the id/ex outputs after the edge
    task automatic run_inst(input word_t inst, input logic e_rd1, input logic e_rd2,
                            input reg_addr_t e_a1, input reg_addr_t e_a2,
                            input alu_op_e e_op, input alu_sel_e e_sel,
                            input word_t e_r1, input word_t e_r2,
                            input reg_addr_t e_wd, input logic e_wreg, input logic e_inv);
        @(posedge clk);
        inst_i      <= inst;
        ex_wreg_i   <= fwd_ex_we;
        ex_wd_i     <= fwd_ex_wd;
        ex_wdata_i  <= fwd_ex_data;
        mem_wreg_i  <= fwd_mem_we;
        mem_wd_i    <= fwd_mem_wd;
        mem_wdata_i <= fwd_mem_data;
        @(negedge clk);
        check_bit("reg1_read_o", e_rd1, reg1_read_o);
        check_bit("reg2_read_o", e_rd2, reg2_read_o);
        check_addr("reg1_addr_o", e_a1, reg1_addr_o);
        check_addr("reg2_addr_o", e_a2, reg2_addr_o);
        @(posedge clk);
        @(negedge clk);
        check_aluop("aluop_o", e_op, aluop_o);
        check_alusel("alusel_o", e_sel, alusel_o);
        check_word("reg1_o", e_r1, reg1_o);
        check_word("reg2_o", e_r2, reg2_o);
        check_addr("wd_o", e_wd, wd_o);
        check_bit("wreg_o", e_wreg, wreg_o);
        check_bit("inst_invalid_o", e_inv, inst_invalid_o);
    endtask

    task automatic clear_forward();
        fwd_ex_we    = 1'b0;
        fwd_ex_wd    = '0;
        fwd_ex_data  = '0;
        fwd_mem_we   = 1'b0;
        fwd_mem_wd   = '0;
        fwd_mem_data = '0;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %-10s %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    task automatic check_nop_outputs();
        check_aluop("aluop_o", alu_nop, aluop_o);
        check_alusel("alusel_o", sel_nop, alusel_o);
        check_word("reg1_o", '0, reg1_o);
        check_word("reg2_o", '0, reg2_o);
        check_addr("wd_o", '0, wd_o);
        check_bit("wreg_o", 1'b0, wreg_o);
        check_bit("inst_invalid_o", 1'b0, inst_invalid_o);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_nop_outputs();   // still in reset
        @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_nop_outputs();
        @(posedge clk);        // captures the sync held during reset
        @(negedge clk);
        check_nop_outputs();
        report_test("reset", e0);
    endtask

    task automatic rr_expect(input func_e f, output alu_op_e op, output alu_sel_e sel);
        case (f)
            func_and:  begin op = alu_and;  sel = sel_logic; end
            func_or:   begin op = alu_or;   sel = sel_logic; end
            func_xor:  begin op = alu_xor;  sel = sel_logic; end
            func_nor:  begin op = alu_nor;  sel = sel_logic; end
            func_sllv: begin op = alu_sll;  sel = sel_shift; end
            func_srlv: begin op = alu_srl;  sel = sel_shift; end
            func_srav: begin op = alu_sra;  sel = sel_shift; end
            func_add:  begin op = alu_add;  sel = sel_arith; end
            func_addu: begin op = alu_addu; sel = sel_arith; end
            func_sub:  begin op = alu_sub;  sel = sel_arith; end
            func_subu: begin op = alu_subu; sel = sel_arith; end
            func_slt:  begin op = alu_slt;  sel = sel_arith; end
            default:   begin op = alu_sltu; sel = sel_arith; end
        endcase
    endtask

    task automatic test_reg_reg();
        func_e     fl [13];
        alu_op_e   op;
        alu_sel_e  sel;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        int        e0;
        e0 = errors;
        fl = '{func_and, func_or, func_xor, func_nor, func_sllv, func_srlv, func_srav,
               func_add, func_addu, func_sub, func_subu, func_slt, func_sltu};
        foreach (fl[i]) begin
            rs = reg_addr_t'(rand_bits(5));
            rt = reg_addr_t'(rand_bits(5));
            rd = reg_addr_t'(rand_bits(5));
            rr_expect(fl[i], op, sel);
            run_inst(enc_r(fl[i], rs, rt, rd, 5'd0), 1'b1, 1'b1, rs, rt, op, sel,
                     rf[rs], rf[rt], rd, 1'b1, 1'b0);
        end
        report_test("reg_reg", e0);
    endtask

    task automatic test_immediate();
        logic [15:0] imm;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  sa;
        int          e0;
        e0 = errors;
        rs = 5'd3;
        rt = 5'd12;
        rd = 5'd21;
        imm = 16'h8000 | 16'(rand_bits(16));   // bit 15 set
        sa = 5'(rand_bits(5));
        run_inst(enc_i(op_andi, rs, rt, imm), 1'b1, 1'b0, rs, '0, alu_and, sel_logic,
                 rf[rs], {16'h0, imm}, rt, 1'b1, 1'b0);
        run_inst(enc_i(op_ori, rs, rt, imm), 1'b1, 1'b0, rs, '0, alu_or, sel_logic,
                 rf[rs], {16'h0, imm}, rt, 1'b1, 1'b0);
        run_inst(enc_i(op_xori, rs, rt, imm), 1'b1, 1'b0, rs, '0, alu_xor, sel_logic,
                 rf[rs], {16'h0, imm}, rt, 1'b1, 1'b0);
        run_inst(enc_i(op_addi, rs, rt, imm), 1'b1, 1'b0, rs, '0, alu_addi, sel_arith,
                 rf[rs], {16'hffff, imm}, rt, 1'b1, 1'b0);
        run_inst(enc_i(op_addiu, rs, rt, imm), 1'b1, 1'b0, rs, '0, alu_addiu, sel_arith,
                 rf[rs], {16'hffff, imm}, rt, 1'b1, 1'b0);
        run_inst(enc_i(op_slti, rs, rt, imm), 1'b1, 1'b0, rs, '0, alu_slt, sel_arith,
                 rf[rs], {16'hffff, imm}, rt, 1'b1, 1'b0);
        run_inst(enc_i(op_sltiu, rs, rt, imm), 1'b1, 1'b0, rs, '0, alu_sltu, sel_arith,
                 rf[rs], {16'hffff, imm}, rt, 1'b1, 1'b0);
        run_inst(enc_i(op_lui, rs, rt, imm), 1'b1, 1'b0, rs, '0, alu_or, sel_logic,
                 rf[rs], {imm, 16'h0}, rt, 1'b1, 1'b0);
        // constant shifts read rt only, shift amount lands in operand 1
        run_inst(enc_r(func_sll, 5'd0, rt, rd, sa), 1'b0, 1'b1, '0, rt, alu_sll, sel_shift,
                 {27'h0, sa}, rf[rt], rd, 1'b1, 1'b0);
        run_inst(enc_r(func_srl, 5'd0, rt, rd, sa), 1'b0, 1'b1, '0, rt, alu_srl, sel_shift,
                 {27'h0, sa}, rf[rt], rd, 1'b1, 1'b0);
        run_inst(enc_r(func_sra, 5'd0, rt, rd, sa), 1'b0, 1'b1, '0, rt, alu_sra, sel_shift,
                 {27'h0, sa}, rf[rt], rd, 1'b1, 1'b0);
        report_test("immediate", e0);
    endtask

    task automatic forward_add(input reg_addr_t rs, input reg_addr_t rt);
        run_inst(enc_r(func_add, rs, rt, 5'd9, 5'd0), 1'b1, 1'b1, rs, rt, alu_add, sel_arith,
                 exp_operand(1'b1, rs, '0), exp_operand(1'b1, rt, '0), 5'd9, 1'b1, 1'b0);
    endtask

    task automatic test_forwarding();
        int e0;
        e0 = errors;
        fwd_ex_we    = 1'b1;
        fwd_ex_wd    = 5'd5;
        fwd_ex_data  = rand_bits(32);
        fwd_mem_we   = 1'b1;
        fwd_mem_wd   = 5'd5;
        fwd_mem_data = rand_bits(32);
        forward_add(5'd5, 5'd6);   // both hit, ex wins
        fwd_ex_wd = 5'd17;
        forward_add(5'd5, 5'd6);   // mem only
        fwd_ex_wd  = 5'd5;
        fwd_ex_we  = 1'b0;
        fwd_mem_we = 1'b0;
        forward_add(5'd5, 5'd6);   // enables low, register file
        clear_forward();
        report_test("forward", e0);
    endtask

    task automatic move_case(input func_e f, input reg_addr_t rt);
        word_t   src2;
        alu_op_e op;
        logic    we;
        src2 = exp_operand(1'b1, rt, '0);
        op   = (f == func_movz) ? alu_movz : alu_movn;
        we   = (f == func_movz) ? (src2 == '0) : (src2 != '0);
        run_inst(enc_r(f, 5'd2, rt, 5'd14, 5'd0), 1'b1, 1'b1, 5'd2, rt, op, sel_move,
                 exp_operand(1'b1, 5'd2, '0), src2, 5'd14, we, 1'b0);
    endtask

    task automatic test_cond_move();
        int e0;
        e0 = errors;
        move_case(func_movz, 5'd7);    // r7 holds zero
        move_case(func_movn, 5'd7);
        move_case(func_movz, 5'd8);
        move_case(func_movn, 5'd8);
        fwd_ex_we   = 1'b1;
        fwd_ex_wd   = 5'd8;
        fwd_ex_data = '0;              // forwarded zero over a nonzero register
        move_case(func_movz, 5'd8);
        move_case(func_movn, 5'd8);
        fwd_ex_wd   = 5'd7;
        fwd_ex_data = 32'h0000_0100;
        move_case(func_movz, 5'd7);
        move_case(func_movn, 5'd7);
        clear_forward();
        report_test("cond_move", e0);
    endtask

    task automatic test_invalid_nop();
        int e0;
        e0 = errors;
        run_inst(enc_i(6'b000001, 5'd4, 5'd5, 16'h1234), 1'b0, 1'b0, '0, '0, alu_nop, sel_nop,
                 '0, '0, '0, 1'b0, 1'b1);
        run_inst(enc_r(6'b000001, 5'd4, 5'd5, 5'd6, 5'd0), 1'b0, 1'b0, '0, '0, alu_nop, sel_nop,
                 '0, '0, '0, 1'b0, 1'b1);
        run_inst(enc_r(func_sync, 5'd0, 5'd0, 5'd0, 5'd0), 1'b0, 1'b0, '0, '0, alu_nop, sel_nop,
                 '0, '0, '0, 1'b0, 1'b0);
        run_inst(enc_i(op_pref, 5'd4, 5'd5, 16'h0040), 1'b0, 1'b0, '0, '0, alu_nop, sel_nop,
                 '0, '0, '0, 1'b0, 1'b0);
        report_test("invalid", e0);
    endtask

    initial begin
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        inst_i      = enc_r(func_sync, 5'd0, 5'd0, 5'd0, 5'd0);
        ex_wreg_i   = 1'b0;
        ex_wd_i     = '0;
        ex_wdata_i  = '0;
        mem_wreg_i  = 1'b0;
        mem_wd_i    = '0;
        mem_wdata_i = '0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        lfsr_state  = 32'h401f;
        clear_forward();
        foreach (rf[i]) rf[i] = rand_bits(32);
        rf[7] = '0;
        rf[8] = rf[8] | 32'h1;

        test_reset();
        test_reg_reg();
        test_immediate();
        test_forwarding();
        test_cond_move();
        test_invalid_nop();

        errors = errors + dut_i.u_sva.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("timeout after %0d ns, tests did not finish", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== verif/id_stage_sva.sv ====
// concurrent assertions on the id_stage outputs, bound to the top level
`timescale 1ns/1ps

module id_stage_sva import id_pkg::*; (
    input logic      clk,
    input logic      arst_n_i,
    input logic      wreg_o,
    input logic      inst_invalid_o,
    input logic      reg1_read_o,
    input reg_addr_t reg1_addr_o
);

    int fail_count = 0;

    // first edge out of reset still shows the bubble
    a_reset_nop: assert property (@(posedge clk) $rose(arst_n_i) |-> !wreg_o)
        else begin
            $error("wreg_o high right after reset");
            fail_count++;
        end

    a_invalid_no_write: assert property (
        @(posedge clk) disable iff (!arst_n_i) inst_invalid_o |-> !wreg_o)
        else begin
            $error("invalid instruction with write enable");
            fail_count++;
        end

    a_idle_port_addr: assert property (
        @(posedge clk) disable iff (!arst_n_i) !reg1_read_o |-> (reg1_addr_o == '0))
        else begin
            $error("reg1 address nonzero while port idle");
            fail_count++;
        end

endmodule

bind id_stage id_stage_sva u_sva (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .wreg_o         (wreg_o),
    .inst_invalid_o (inst_invalid_o),
    .reg1_read_o    (reg1_read_o),
    .reg1_addr_o    (reg1_addr_o)
);

// ==== list.f ====
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/operand_select.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
verif/id_stage_tb.sv
verif/id_stage_sva.sv

// ==== Makefile ====
# Verilator build and run for the id_stage testbench

VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
